/* Bender.yml */
package:
  name: issue_stage

export_include_dirs:
  - source

sources:
  - files:
      - source/issue_pkg.sv
      - source/pair_hazard.sv
      - source/issue_select.sv
      - source/scoreboard.sv
      - source/issue_top.sv
  - target: simulation
    files:
      - verification/issue_properties.sv
      - verification/issue_tb.sv

/* build.f */
+incdir+source
source/issue_pkg.sv
source/pair_hazard.sv
source/issue_select.sv
source/scoreboard.sv
source/issue_top.sv
verification/issue_properties.sv
verification/issue_tb.sv

/* source/issue_macros.svh */
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// operand use time
// ex means the value must be forwardable when the consumer enters ex
`define ISSUE_USE_EX 1'b0
// m2 means the consumer only needs the value late, in m2
`define ISSUE_USE_M2 1'b1

// result ready time
// alu style results are forwardable from ex on
`define ISSUE_READY_EX 1'b0
// loads and other long results only from m2
`define ISSUE_READY_M2 1'b1

// architectural limits
`define ISSUE_NUM_REGS 32
`define ISSUE_NUM_STAGES 3

`endif

/* source/issue_pkg.sv */
`include "issue_macros.svh"

package issue_pkg;

	// architectural register index
	typedef logic [$clog2(`ISSUE_NUM_REGS)-1:0] reg_idx_t;

	// one bit per back-end stage
	// bit 0 ex, bit 1 m1, bit 2 m2
	typedef logic [`ISSUE_NUM_STAGES-1:0] stage_vec_t;

	// use or ready time code, see issue_macros.svh
	typedef logic time_code_t;

	// one decoded instruction as seen by issue
	typedef struct packed {
		// destination, zero means no write
		reg_idx_t w_reg;
		// two sources
		reg_idx_t [1:0] r_reg;
		// per source use time
		time_code_t [1:0] use_time;
		// when the result can be forwarded
		time_code_t ready_time;
		// branch, privileged, load/store
		logic pipe_one;
		// mul/div
		logic pipe_two;
		// serialize everything behind this one
		logic wait_hint;
	} inst_t;

	// scoreboard entry for one register
	typedef struct packed {
		// pipe holding the pending writer
		logic pipe_sel;
		// one-hot stage, moves toward m2
		stage_vec_t pos;
		// readiness per stage, moves toward ex
		stage_vec_t fwd_ready;
	} sb_entry_t;

	// forwarding selects for one operand
	typedef struct packed {
		logic fwd_pipe;
		// bit 0 regfile, bits 1..3 ex/m1/m2 producer
		logic [3:0] ex_src;
		logic [2:0] m1_src;
		logic [1:0] m2_src;
	} fwd_info_t;

endpackage

/* source/issue_select.sv */
module issue_select (
	input logic [1:0] inst_valid_i,
	input logic [1:0] raw_block_i,
	input logic pair_block_i,
	input logic stall_i,
	input logic clr_frontend_i,
	// class bits of the pair
	input logic first_pipe_two_i,
	input logic second_pipe_one_i,
	// 00, 01 or 11 only
	output logic [1:0] issue_o,
	// 1 swaps the pair across the pipes
	output logic revert_o
);

	logic issue_first;
	logic issue_second;

	// head goes unless blocked by an older writer or held by the front
	assign issue_first = inst_valid_i[0] & ~raw_block_i[0] & ~stall_i & ~clr_frontend_i;

	// in order, younger only rides along with the older
	assign issue_second = issue_first & inst_valid_i[1] & ~raw_block_i[1] & ~pair_block_i;

	assign issue_o = {issue_second, issue_first};

	// pipe_one work lands on pipe 0, pipe_two work on pipe 1
	assign revert_o = (issue_second & second_pipe_one_i)
		| (issue_first & first_pipe_two_i);

endmodule

/* source/issue_top.sv */
module issue_top import issue_pkg::*; (
	input logic clk,
	input logic rst_n,
	input inst_t [1:0] inst_i,
	input logic [1:0] inst_valid_i,
	input stage_vec_t [1:0] stall_vec_i,
	input stage_vec_t [1:0] clr_vec_i,
	input logic stall_i,
	input logic clr_frontend_i,
	output logic [1:0] issue_o,
	output logic revert_o,
	output fwd_info_t [1:0][1:0] fwd_info_o
);

	// per instruction verdict against in-flight writers
	logic [1:0] raw_block;
	// younger against older in the same cycle
	logic pair_block;

	// issue decisions loop back into the table
	scoreboard u_scoreboard (
		.clk(clk),
		.rst_n(rst_n),
		.inst_i(inst_i),
		.issue_i(issue_o),
		.revert_i(revert_o),
		.stall_vec_i(stall_vec_i),
		.clr_vec_i(clr_vec_i),
		.raw_block_o(raw_block),
		.fwd_info_o(fwd_info_o)
	);

	pair_hazard u_pair_hazard (
		.first_i(inst_i[0]),
		.second_i(inst_i[1]),
		.pair_block_o(pair_block)
	);

	issue_select u_issue_select (
		.inst_valid_i(inst_valid_i),
		.raw_block_i(raw_block),
		.pair_block_i(pair_block),
		.stall_i(stall_i),
		.clr_frontend_i(clr_frontend_i),
		.first_pipe_two_i(inst_i[0].pipe_two),
		.second_pipe_one_i(inst_i[1].pipe_one),
		.issue_o(issue_o),
		.revert_o(revert_o)
	);

endmodule

/* source/pair_hazard.sv */
module pair_hazard import issue_pkg::*; (
	// older instruction
	input inst_t first_i,
	// younger instruction
	input inst_t second_i,
	output logic pair_block_o
);

	logic data_hit;
	logic class_hit;
	logic serial_hit;

	// younger reads or rewrites what the older writes
	// r0 writes don't count
	assign data_hit = (first_i.w_reg != '0)
		&& ((first_i.w_reg == second_i.r_reg[0])
		|| (first_i.w_reg == second_i.r_reg[1])
		|| (first_i.w_reg == second_i.w_reg));

	// each pipe takes one of its own class per cycle
	// a younger pipe_one never pairs so the older can't be flushed past it
	// which also covers two pipe_one in one pair
	assign class_hit = (first_i.pipe_two & second_i.pipe_two)
		| second_i.pipe_one;

	// older asks to go alone
	assign serial_hit = first_i.wait_hint;

	assign pair_block_o = data_hit | class_hit | serial_hit;

endmodule

/* source/scoreboard.sv */
`include "issue_macros.svh"

module scoreboard import issue_pkg::*; (
	input logic clk,
	input logic rst_n,
	input inst_t [1:0] inst_i,
	input logic [1:0] issue_i,
	input logic revert_i,
	// per pipe stage vectors
	input stage_vec_t [1:0] stall_vec_i,
	input stage_vec_t [1:0] clr_vec_i,
	output logic [1:0] raw_block_o,
	// indexed by instruction, then by source
	output fwd_info_t [1:0][1:0] fwd_info_o
);

	// one entry per architectural register
	sb_entry_t [`ISSUE_NUM_REGS-1:0] sb_q;
	sb_entry_t [`ISSUE_NUM_REGS-1:0] sb_d;

	// returns 1 when the source cannot be read yet
	function automatic logic raw_hit(input sb_entry_t ent, input time_code_t use_time);
		logic ok;
		ok = 1'b0;
		unique case (use_time)
			// needs the value at ex entry
			`ISSUE_USE_EX: ok = (ent.pos == '0) || ent.fwd_ready[0];
			// any forwardable stage will do, it catches up by m2
			`ISSUE_USE_M2: ok = (ent.pos == '0) || (|ent.fwd_ready);
		endcase
		return ~ok;
	endfunction

	// one-hot source selects per consumer stage
	function automatic fwd_info_t fwd_gen(input sb_entry_t ent);
		fwd_info_t f;
		f.fwd_pipe = ent.pipe_sel;
		// consumer in ex sees producers in ex, m1, m2
		f.ex_src[3:1] = ent.pos & {3{ent.fwd_ready[0]}};
		f.ex_src[0] = ~|f.ex_src[3:1];
		// consumer in m1 sees producers in m1, m2
		f.m1_src[2:1] = ent.pos[1:0] & {2{ent.fwd_ready[1]}};
		f.m1_src[0] = ~|f.m1_src[2:1];
		// consumer in m2 only from m2
		f.m2_src[1] = ent.pos[0] & ent.fwd_ready[2];
		f.m2_src[0] = ~f.m2_src[1];
		return f;
	endfunction

	// move one entry a stage along its pipe
	function automatic sb_entry_t age_entry(
		input sb_entry_t ent,
		input stage_vec_t stall_vec,
		input stage_vec_t clr_vec
	);
		sb_entry_t nxt;
		nxt.pipe_sel = ent.pipe_sel;
		// plain advance
		nxt.pos = {ent.pos[1:0], 1'b0};
		nxt.fwd_ready = {1'b0, ent.fwd_ready[2:1]};
		// flushed writer keeps moving but never forwards
		if (|(ent.pos & clr_vec)) begin
			nxt.fwd_ready = '0;
		end
		// stall beats clear
		if (|(ent.pos & stall_vec)) begin
			nxt.pos = ent.pos;
			nxt.fwd_ready = ent.fwd_ready;
		end
		return nxt;
	endfunction

	// fresh entry for a writer entering ex
	function automatic sb_entry_t issue_entry(input inst_t inst, input logic pipe);
		sb_entry_t nxt;
		nxt.pipe_sel = pipe;
		nxt.pos = 3'b001;
		nxt.fwd_ready = '0;
		unique case (inst.ready_time)
			`ISSUE_READY_EX: nxt.fwd_ready = 3'b111;
			// only the m2 slot, shifts down into ex readiness later
			`ISSUE_READY_M2: nxt.fwd_ready = 3'b100;
		endcase
		return nxt;
	endfunction

	// next state, issue overrides aging
	always_comb begin
		for (int e = 0; e < `ISSUE_NUM_REGS; e++) begin
			sb_d[e] = age_entry(sb_q[e], stall_vec_i[sb_q[e].pipe_sel],
				clr_vec_i[sb_q[e].pipe_sel]);
			// slot 1 last so it wins on a shared destination
			for (int k = 0; k < 2; k++) begin
				if (issue_i[k] && (inst_i[k].w_reg == reg_idx_t'(e))) begin
					sb_d[e] = issue_entry(inst_i[k], k[0] ^ revert_i);
				end
			end
		end
		// r0 never has a pending writer
		sb_d[0] = '0;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sb_q <= '0;
		end else begin
			sb_q <= sb_d;
		end
	end

	// lookups for both instructions, both sources
	always_comb begin
		raw_block_o = '0;
		for (int k = 0; k < 2; k++) begin
			for (int j = 0; j < 2; j++) begin
				raw_block_o[k] = raw_block_o[k]
					| raw_hit(sb_q[inst_i[k].r_reg[j]], inst_i[k].use_time[j]);
				fwd_info_o[k][j] = fwd_gen(sb_q[inst_i[k].r_reg[j]]);
			end
		end
	end

endmodule

/* verification/issue_properties.sv */
module issue_properties (
	input logic clk,
	input logic rst_n,
	input logic [1:0] issue_i,
	input logic revert_i,
	input logic stall_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// younger never goes without the older
	issue_in_order: assert property (@(posedge clk) disable iff (!rst_n)
		issue_i != 2'b10)
		else $error("issue vector 10, younger issued alone");

	// global stall holds the whole pair
	stall_holds_issue: assert property (@(posedge clk) disable iff (!rst_n)
		stall_i |-> issue_i == 2'b00)
		else $error("issue during global stall");

	// swap only makes sense with something issued
	revert_needs_issue: assert property (@(posedge clk) disable iff (!rst_n)
		revert_i |-> issue_i[0])
		else $error("revert set with nothing issued");

endmodule

bind issue_top issue_properties u_issue_properties (
	.clk(clk),
	.rst_n(rst_n),
	.issue_i(issue_o),
	.revert_i(revert_o),
	.stall_i(stall_i)
);

/* verification/issue_tb.sv */
`include "issue_macros.svh"

module issue_tb import issue_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RST_CYCLES = 8;
	// directed section is exactly this long
	localparam int DIR_CYCLES = 20;
	localparam int RAND_CYCLES = 2000;
	localparam int TIMEOUT_CYCLES = RST_CYCLES + DIR_CYCLES + RAND_CYCLES + 100;
	localparam logic [1:0] CLS_ALU = 2'd0;
	localparam logic [1:0] CLS_ONE = 2'd1;
	localparam logic [1:0] CLS_TWO = 2'd2;
	localparam time_code_t UEX = `ISSUE_USE_EX;
	localparam time_code_t UM2 = `ISSUE_USE_M2;
	localparam time_code_t REX = `ISSUE_READY_EX;
	localparam time_code_t RM2 = `ISSUE_READY_M2;
	// every select on the register file
	localparam fwd_info_t FWD_REGFILE = '{fwd_pipe: 1'b0, ex_src: 4'b0001,
		m1_src: 3'b001, m2_src: 2'b01};

	logic clk;
	logic rst_n;
	inst_t [1:0] inst;
	logic [1:0] inst_valid;
	stage_vec_t [1:0] stall_vec;
	stage_vec_t [1:0] clr_vec;
	logic stall;
	logic clr_fe;
	logic [1:0] issue;
	logic revert;
	fwd_info_t [1:0][1:0] fwd_info;
	// reference copy of the register table
	sb_entry_t model_sb [`ISSUE_NUM_REGS];
	logic [31:0] rng;
	int cycle_cnt;
	inst_t nop;

	issue_top UUT (
		.clk(clk),
		.rst_n(rst_n),
		.inst_i(inst),
		.inst_valid_i(inst_valid),
		.stall_vec_i(stall_vec),
		.clr_vec_i(clr_vec),
		.stall_i(stall),
		.clr_frontend_i(clr_fe),
		.issue_o(issue),
		.revert_o(revert),
		.fwd_info_o(fwd_info)
	);

	always #4 clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	// bound on total run length
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout: still running after %0d cycles", TIMEOUT_CYCLES));
		end
	end

	task automatic check_issue(input logic [1:0] got, input logic [1:0] exp, input string name);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string name);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	task automatic check_fwd(input fwd_info_t got, input fwd_info_t exp, input string name);
		if (got !== exp) begin
			abort_run($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp));
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic inst_t make_inst(input reg_idx_t w, input reg_idx_t r0,
		input reg_idx_t r1, input time_code_t u0, input time_code_t u1,
		input time_code_t rdy, input logic [1:0] cls, input logic wh);
		inst_t i;
		i.w_reg = w;
		i.r_reg[0] = r0;
		i.r_reg[1] = r1;
		i.use_time[0] = u0;
		i.use_time[1] = u1;
		i.ready_time = rdy;
		i.pipe_one = (cls == CLS_ONE);
		i.pipe_two = (cls == CLS_TWO);
		i.wait_hint = wh;
		return i;
	endfunction

	// registers 0..7 only, so conflicts come often
	function automatic inst_t rand_inst(input logic [31:0] r);
		return make_inst({2'b00, r[2:0]}, {2'b00, r[5:3]}, {2'b00, r[8:6]},
			r[9], r[10], r[11], r[13:12], r[16:14] == 3'b000);
	endfunction

	// no pending writer, or readiness reached in time
	function automatic logic model_blocked(input sb_entry_t ent, input time_code_t use_t);
		if (ent.pos == 3'b000) return 1'b0;
		if (use_t == UEX) return !ent.fwd_ready[0];
		return ent.fwd_ready == 3'b000;
	endfunction

	function automatic fwd_info_t model_fwd(input sb_entry_t ent);
		fwd_info_t f;
		f = '0;
		f.fwd_pipe = ent.pipe_sel;
		if (ent.fwd_ready[0]) f.ex_src[3:1] = ent.pos;
		if (ent.fwd_ready[1]) f.m1_src[2:1] = ent.pos[1:0];
		if (ent.fwd_ready[2]) f.m2_src[1] = ent.pos[0];
		f.ex_src[0] = (f.ex_src[3:1] == 3'b000);
		f.m1_src[0] = (f.m1_src[2:1] == 2'b00);
		f.m2_src[0] = !f.m2_src[1];
		return f;
	endfunction

	function automatic logic model_pair(input inst_t a, input inst_t b);
		logic hit;
		hit = a.wait_hint || b.pipe_one || (a.pipe_one && b.pipe_one)
			|| (a.pipe_two && b.pipe_two);
		if (a.w_reg != 0) begin
			hit = hit || (a.w_reg == b.r_reg[0]) || (a.w_reg == b.r_reg[1]) || (a.w_reg == b.w_reg);
		end
		return hit;
	endfunction

	// same step the DUT takes at the coming edge
	task automatic update_model(input logic [1:0] iss, input logic rev);
		sb_entry_t nxt [`ISSUE_NUM_REGS];
		sb_entry_t ent;
		logic p;
		for (int e = 0; e < `ISSUE_NUM_REGS; e++) begin
			ent = model_sb[e];
			p = ent.pipe_sel;
			nxt[e] = ent;
			// stalled entries keep everything
			if ((ent.pos & stall_vec[p]) == 3'b000) begin
				nxt[e].pos = ent.pos << 1;
				nxt[e].fwd_ready = ((ent.pos & clr_vec[p]) != 3'b000) ? 3'b000 : ent.fwd_ready >> 1;
			end
		end
		for (int k = 0; k < 2; k++) begin
			if (iss[k] && inst[k].w_reg != 0) begin
				nxt[inst[k].w_reg].pipe_sel = (k == 1) ^ rev;
				nxt[inst[k].w_reg].pos = 3'b001;
				nxt[inst[k].w_reg].fwd_ready = (inst[k].ready_time == REX) ? 3'b111 : 3'b100;
			end
		end
		model_sb = nxt;
	endtask

	// mid cycle, inputs settled since 1 ns after the edge
	task automatic check_cycle();
		logic [1:0] blk;
		logic [1:0] exp_issue;
		logic exp_rev;
		#3;
		for (int k = 0; k < 2; k++) begin
			blk[k] = 1'b0;
			for (int j = 0; j < 2; j++) begin
				blk[k] = blk[k] | model_blocked(model_sb[inst[k].r_reg[j]], inst[k].use_time[j]);
				check_fwd(fwd_info[k][j], model_fwd(model_sb[inst[k].r_reg[j]]),
					$sformatf("fwd_info_o[%0d][%0d]", k, j));
			end
		end
		exp_issue[0] = inst_valid[0] && !blk[0] && !stall && !clr_fe;
		exp_issue[1] = exp_issue[0] && inst_valid[1] && !blk[1] && !model_pair(inst[0], inst[1]);
		exp_rev = (exp_issue[1] && inst[1].pipe_one) || (exp_issue[0] && inst[0].pipe_two);
		check_issue(issue, exp_issue, "issue_o");
		check_bit(revert, exp_rev, "revert_o");
		update_model(issue, revert);
	endtask

	task automatic directed_cycle(input inst_t i0, input inst_t i1, input logic [1:0] valid,
		input stage_vec_t sv, input stage_vec_t cv, input logic st, input logic cf,
		input logic [1:0] exp_issue);
		@(posedge clk);
		#1;
		inst[0] = i0;
		inst[1] = i1;
		inst_valid = valid;
		// only pipe 0 is exercised here
		stall_vec = {3'b000, sv};
		clr_vec = {3'b000, cv};
		stall = st;
		clr_fe = cf;
		check_cycle();
		check_issue(issue, exp_issue, "issue_o directed");
	endtask

	task automatic pair_cycle(input inst_t i0, input inst_t i1, input logic [1:0] valid,
		input logic [1:0] exp_issue);
		directed_cycle(i0, i1, valid, 3'b000, 3'b000, 1'b0, 1'b0, exp_issue);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		inst = '0;
		inst_valid = 2'b00;
		stall_vec = '0;
		clr_vec = '0;
		stall = 1'b0;
		clr_fe = 1'b0;
		rng = 32'h2997;
		cycle_cnt = 0;
		nop = '0;
		foreach (model_sb[e]) model_sb[e] = '0;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst_n = 1'b1;

		// empty table, clean pair goes together from the register file
		pair_cycle(make_inst(1, 2, 3, UEX, UEX, REX, CLS_ALU, 0),
			make_inst(4, 5, 6, UEX, UEX, REX, CLS_ALU, 0), 2'b11, 2'b11);
		for (int k = 0; k < 2; k++) begin
			for (int j = 0; j < 2; j++) begin
				check_fwd(fwd_info[k][j], FWD_REGFILE, $sformatf("fwd_info_o[%0d][%0d]", k, j));
			end
		end
		// late load result, ex consumer waits two cycles
		pair_cycle(make_inst(2, 0, 0, UEX, UEX, RM2, CLS_ONE, 0), nop, 2'b01, 2'b01);
		pair_cycle(make_inst(0, 2, 0, UEX, UEX, REX, CLS_ALU, 0), nop, 2'b01, 2'b00);
		pair_cycle(make_inst(0, 2, 0, UEX, UEX, REX, CLS_ALU, 0), nop, 2'b01, 2'b00);
		pair_cycle(make_inst(0, 2, 0, UEX, UEX, REX, CLS_ALU, 0), nop, 2'b01, 2'b01);
		// m2 consumer goes right behind the load
		pair_cycle(make_inst(3, 0, 0, UEX, UEX, RM2, CLS_ONE, 0), nop, 2'b01, 2'b01);
		pair_cycle(make_inst(0, 3, 0, UM2, UEX, REX, CLS_ALU, 0), nop, 2'b01, 2'b01);
		// pair conflicts
		pair_cycle(make_inst(6, 0, 0, UEX, UEX, REX, CLS_ALU, 0),
			make_inst(0, 6, 0, UEX, UEX, REX, CLS_ALU, 0), 2'b11, 2'b01);
		pair_cycle(make_inst(0, 0, 0, UEX, UEX, REX, CLS_TWO, 0),
			make_inst(0, 0, 0, UEX, UEX, REX, CLS_TWO, 0), 2'b11, 2'b01);
		check_bit(revert, 1'b1, "revert_o directed");
		pair_cycle(nop, make_inst(0, 0, 0, UEX, UEX, REX, CLS_ONE, 0), 2'b11, 2'b01);
		pair_cycle(make_inst(0, 0, 0, UEX, UEX, REX, CLS_ALU, 1), nop, 2'b11, 2'b01);
		pair_cycle(make_inst(0, 0, 0, UEX, UEX, REX, CLS_ONE, 0),
			make_inst(0, 0, 0, UEX, UEX, REX, CLS_TWO, 0), 2'b11, 2'b11);
		check_bit(revert, 1'b0, "revert_o directed");
		pair_cycle(make_inst(0, 0, 0, UEX, UEX, REX, CLS_TWO, 0), nop, 2'b11, 2'b11);
		check_bit(revert, 1'b1, "revert_o directed");
		// writer r5 on pipe 0, then stall, stall with clear, clear alone
		pair_cycle(make_inst(5, 0, 0, UEX, UEX, REX, CLS_ALU, 0), nop, 2'b01, 2'b01);
		directed_cycle(make_inst(0, 5, 0, UM2, UEX, REX, CLS_ALU, 0), nop, 2'b01,
			3'b001, 3'b000, 1'b0, 1'b0, 2'b01);
		directed_cycle(make_inst(0, 5, 0, UEX, UEX, REX, CLS_ALU, 0), nop, 2'b01,
			3'b001, 3'b001, 1'b0, 1'b0, 2'b01);
		directed_cycle(make_inst(0, 5, 0, UEX, UEX, REX, CLS_ALU, 0), nop, 2'b01,
			3'b000, 3'b001, 1'b0, 1'b0, 2'b01);
		// flushed writer moved on but forwards nothing
		pair_cycle(make_inst(0, 5, 0, UEX, UEX, REX, CLS_ALU, 0), nop, 2'b01, 2'b00);
		// front end holds
		directed_cycle(nop, nop, 2'b11, 3'b000, 3'b000, 1'b1, 1'b0, 2'b00);
		directed_cycle(nop, nop, 2'b11, 3'b000, 3'b000, 1'b0, 1'b1, 2'b00);

		// mixed random traffic, sparse stalls and clears
		repeat (RAND_CYCLES) begin
			@(posedge clk);
			#1;
			rng = xorshift(rng);
			inst[0] = rand_inst(rng);
			rng = xorshift(rng);
			inst[1] = rand_inst(rng);
			rng = xorshift(rng);
			inst_valid = {rng[1] | rng[2], rng[0] | rng[3]};
			stall = (rng[7:4] == 4'h0);
			clr_fe = (rng[11:8] == 4'h0);
			rng = xorshift(rng);
			stall_vec[0] = (rng[3:0] == 4'h0) ? rng[6:4] : 3'b000;
			clr_vec[0] = (rng[11:8] == 4'h0) ? rng[14:12] : 3'b000;
			stall_vec[1] = (rng[19:16] == 4'h0) ? rng[22:20] : 3'b000;
			clr_vec[1] = (rng[27:24] == 4'h0) ? rng[30:28] : 3'b000;
			check_cycle();
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
